// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/cachePkg.sv
  - hdl/memBusPkg.sv
  - hdl/tagIf.sv
  - hdl/refillIf.sv
  - hdl/dataSram.sv
  - hdl/tagValidArray.sv
  - hdl/refillUnit.sv
  - hdl/cacheCtrl.sv
  - hdl/cacheTop.sv
  - target: test
    files:
      - verif/cacheTop_checker.sv
      - verif/cacheTb.sv

// ==== flist.f ====
hdl/cachePkg.sv
hdl/memBusPkg.sv
hdl/tagIf.sv
hdl/refillIf.sv
hdl/dataSram.sv
hdl/tagValidArray.sv
hdl/refillUnit.sv
hdl/cacheCtrl.sv
hdl/cacheTop.sv
verif/cacheTop_checker.sv
verif/cacheTb.sv

// ==== hdl/cacheCtrl.sv ====
module cacheCtrl #(
  parameter int SETS = 64,
  parameter int SRAM_W = 128,
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cachePkg::ADDR_W - IDX_W - cachePkg::OFFSET_W,
  localparam int SRAM_B = SRAM_W / 8,
  localparam int PER_WAY = memBusPkg::LINE_W / SRAM_W,
  localparam int NSRAM = 2 * PER_WAY
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              valid_i,
  input  cachePkg::memOp_e                  op_i,
  input  logic [cachePkg::ADDR_W-1:0]       addr_i,
  input  logic [cachePkg::XLEN-1:0]         wr_data_i,
  input  logic [cachePkg::XLEN/8-1:0]       wr_mask_i,
  output logic                              addr_ok_o,
  output logic                              data_ok_o,
  output logic [cachePkg::XLEN-1:0]         rd_data_o,
  tagIf.ctrl                                tagPort,
  refillIf.ctrl                             refillPort,
  output logic                              sramEn_o,
  output logic [NSRAM-1:0]                  sramWrEn_o,
  output logic [NSRAM-1:0][SRAM_B-1:0]      sramByteEn_o,
  output logic [IDX_W-1:0]                  sramIndex_o,
  output logic [NSRAM-1:0][SRAM_W-1:0]      sramWrData_o,
  input  logic [NSRAM-1:0][SRAM_W-1:0]      sramRdData_i
);

  localparam int XLEN = cachePkg::XLEN;
  localparam int WORD_BYTES = XLEN / 8;
  localparam int LINE_BYTES = cachePkg::LINE_BYTES;
  localparam int OFFSET_W = cachePkg::OFFSET_W;

  cachePkg::cacheState_e stateQ, stateD;

  // request latch
  cachePkg::memOp_e reqOp;
  logic [cachePkg::ADDR_W-1:0] reqAddr;
  logic [XLEN-1:0] reqData;
  logic [WORD_BYTES-1:0] reqMask;

  logic [IDX_W-1:0] reqIndex;
  logic [IDX_W-1:0] newIndex;
  logic [cachePkg::WORD_SEL_W-1:0] reqWord;
  logic accept;
  logic lookupHit;
  logic storeHit;
  logic lineWrite;
  logic [memBusPkg::LINE_W-1:0] hitLine;
  logic [memBusPkg::LINE_W-1:0] mergedLine;
  logic [memBusPkg::LINE_W-1:0] wrLine;
  logic [XLEN-1:0] hitWord;
  logic [XLEN-1:0] mergedWord;
  logic [LINE_BYTES-1:0] wrLineBe;
  logic [1:0] wrWayEn;

  assign reqIndex = reqAddr[OFFSET_W +: IDX_W];
  assign newIndex = addr_i[OFFSET_W +: IDX_W];
  assign reqWord = reqAddr[OFFSET_W-1 -: cachePkg::WORD_SEL_W];

  assign lookupHit = (stateQ == cachePkg::LOOKUP) && tagPort.hit;
  assign storeHit = lookupHit && (reqOp == cachePkg::OP_WRITE);
  assign lineWrite = (stateQ == cachePkg::REFILL) && refillPort.done;

  // a read hit frees the pipe for the next request, a store hit uses the SRAM port
  assign accept = valid_i && ((stateQ == cachePkg::IDLE) ||
                              (lookupHit && reqOp == cachePkg::OP_READ));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= cachePkg::IDLE;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      cachePkg::IDLE: begin
        if (accept) begin
          stateD = cachePkg::LOOKUP;
        end
      end
      cachePkg::LOOKUP: begin
        if (!tagPort.hit) begin
          stateD = cachePkg::MISS;
        end else if (accept) begin
          stateD = cachePkg::LOOKUP;
        end else begin
          stateD = cachePkg::IDLE;
        end
      end
      cachePkg::MISS: stateD = cachePkg::REFILL;
      cachePkg::REFILL: begin
        if (refillPort.done) begin
          stateD = cachePkg::REPLAY;
        end
      end
      // tags and data were written on done, the next lookup must hit
      cachePkg::REPLAY: stateD = cachePkg::LOOKUP;
      default: stateD = cachePkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqOp <= op_i;
      reqAddr <= addr_i;
      reqData <= wr_data_i;
      reqMask <= wr_mask_i;
    end
  end

  // gather the hit way's line from its SRAMs
  always_comb begin
    for (int p = 0; p < PER_WAY; p++) begin
      hitLine[p*SRAM_W +: SRAM_W] = sramRdData_i[tagPort.hitWay * PER_WAY + p];
    end
  end

  assign hitWord = hitLine[reqWord*XLEN +: XLEN];

  // store merge, masked bytes from the request and the rest from the line
  always_comb begin
    for (int b = 0; b < WORD_BYTES; b++) begin
      mergedWord[b*8 +: 8] = reqMask[b] ? reqData[b*8 +: 8] : hitWord[b*8 +: 8];
    end
    mergedLine = hitLine;
    mergedLine[reqWord*XLEN +: XLEN] = mergedWord;
  end

  assign wrLine = lineWrite ? refillPort.lineData : mergedLine;
  assign wrLineBe = lineWrite ? '1 :
                    (LINE_BYTES'({WORD_BYTES{1'b1}}) << (reqWord * WORD_BYTES));

  always_comb begin
    wrWayEn = 2'b00;
    if (lineWrite) begin
      wrWayEn[tagPort.victimWay] = 1'b1;
    end else if (storeHit) begin
      wrWayEn[tagPort.hitWay] = 1'b1;
    end
  end

  always_comb begin
    for (int s = 0; s < NSRAM; s++) begin
      sramWrEn_o[s] = wrWayEn[s / PER_WAY];
      sramByteEn_o[s] = wrLineBe[(s % PER_WAY)*SRAM_B +: SRAM_B];
      sramWrData_o[s] = wrLine[(s % PER_WAY)*SRAM_W +: SRAM_W];
    end
  end

  assign sramEn_o = accept || storeHit || lineWrite || (stateQ == cachePkg::REPLAY);
  assign sramIndex_o = accept ? newIndex : reqIndex;

  assign tagPort.lookupEn = accept || (stateQ == cachePkg::REPLAY);
  assign tagPort.lookupIndex = accept ? newIndex : reqIndex;
  assign tagPort.cmpTag = reqAddr[cachePkg::ADDR_W-1 -: TAG_W];
  assign tagPort.updateEn = lineWrite;
  assign tagPort.updateWay = tagPort.victimWay;
  assign tagPort.touchEn = lookupHit;

  assign refillPort.start = (stateQ == cachePkg::MISS);
  assign refillPort.lineAddr = {reqAddr[cachePkg::ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  assign addr_ok_o = accept;
  assign data_ok_o = lookupHit;
  assign rd_data_o = hitWord;

endmodule

// ==== hdl/cachePkg.sv ====
package cachePkg;

  // data word and address widths
  localparam int XLEN = 64;
  localparam int ADDR_W = 32;

  // line geometry
  localparam int LINE_BYTES = 32;
  localparam int OFFSET_W = $clog2(LINE_BYTES);

  // word select, address bits 4 down to 3
  localparam int WORD_SEL_W = 2;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS,
    REFILL,
    REPLAY
  } cacheState_e;

  // pipeline request opcode
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } memOp_e;

endpackage

// ==== hdl/cacheTop.sv ====
module cacheTop #(
  parameter int SETS = 64,
  parameter int SRAM_W = 128,
  localparam int IDX_W = $clog2(SETS),
  localparam int SRAM_B = SRAM_W / 8
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // pipeline side
  input  logic                         valid_i,
  input  cachePkg::memOp_e             op_i,
  input  logic [cachePkg::ADDR_W-1:0]  addr_i,
  input  logic [cachePkg::XLEN-1:0]    wr_data_i,
  input  logic [cachePkg::XLEN/8-1:0]  wr_mask_i,
  output logic                         addr_ok_o,
  output logic                         data_ok_o,
  output logic [cachePkg::XLEN-1:0]    rd_data_o,
  // refill side
  output logic                         cacheRdValid_o,
  output logic [cachePkg::ADDR_W-1:0]  cacheAddr_o,
  input  logic                         rdDataValid_i,
  input  logic                         rdLast_i,
  input  logic [memBusPkg::BEAT_W-1:0] rdData_i
);

  logic                         sramEn;
  logic [3:0]                   sramWrEn;
  logic [3:0][SRAM_B-1:0]       sramByteEn;
  logic [IDX_W-1:0]             sramIndex;
  logic [3:0][SRAM_W-1:0]       sramWrData;
  logic [3:0][SRAM_W-1:0]       sramRdData;

  tagIf #(.SETS(SETS)) tagBus ();
  refillIf refillBus ();

  cacheCtrl #(
    .SETS  (SETS),
    .SRAM_W(SRAM_W)
  ) ctrlInst (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .addr_i      (addr_i),
    .wr_data_i   (wr_data_i),
    .wr_mask_i   (wr_mask_i),
    .addr_ok_o   (addr_ok_o),
    .data_ok_o   (data_ok_o),
    .rd_data_o   (rd_data_o),
    .tagPort     (tagBus.ctrl),
    .refillPort  (refillBus.ctrl),
    .sramEn_o    (sramEn),
    .sramWrEn_o  (sramWrEn),
    .sramByteEn_o(sramByteEn),
    .sramIndex_o (sramIndex),
    .sramWrData_o(sramWrData),
    .sramRdData_i(sramRdData)
  );

  tagValidArray #(.SETS(SETS)) arrayInst (
    .clk    (clk),
    .rst_n  (rst_n),
    .tagPort(tagBus.array)
  );

  refillUnit refillInst (
    .clk           (clk),
    .rst_n         (rst_n),
    .refillPort    (refillBus.refill),
    .cacheRdValid_o(cacheRdValid_o),
    .cacheAddr_o   (cacheAddr_o),
    .rdDataValid_i (rdDataValid_i),
    .rdLast_i      (rdLast_i),
    .rdData_i      (rdData_i)
  );

  // lo holds words 0 and 1 of a line, hi holds words 2 and 3
  dataSram #(.SETS(SETS), .SRAM_W(SRAM_W)) way0Lo (
    .clk     (clk),
    .en_i    (sramEn),
    .wrEn_i  (sramWrEn[0]),
    .byteEn_i(sramByteEn[0]),
    .addr_i  (sramIndex),
    .wrData_i(sramWrData[0]),
    .rdData_o(sramRdData[0])
  );

  dataSram #(.SETS(SETS), .SRAM_W(SRAM_W)) way0Hi (
    .clk     (clk),
    .en_i    (sramEn),
    .wrEn_i  (sramWrEn[1]),
    .byteEn_i(sramByteEn[1]),
    .addr_i  (sramIndex),
    .wrData_i(sramWrData[1]),
    .rdData_o(sramRdData[1])
  );

  dataSram #(.SETS(SETS), .SRAM_W(SRAM_W)) way1Lo (
    .clk     (clk),
    .en_i    (sramEn),
    .wrEn_i  (sramWrEn[2]),
    .byteEn_i(sramByteEn[2]),
    .addr_i  (sramIndex),
    .wrData_i(sramWrData[2]),
    .rdData_o(sramRdData[2])
  );

  dataSram #(.SETS(SETS), .SRAM_W(SRAM_W)) way1Hi (
    .clk     (clk),
    .en_i    (sramEn),
    .wrEn_i  (sramWrEn[3]),
    .byteEn_i(sramByteEn[3]),
    .addr_i  (sramIndex),
    .wrData_i(sramWrData[3]),
    .rdData_o(sramRdData[3])
  );

endmodule

// ==== hdl/dataSram.sv ====
module dataSram #(
  parameter int SETS = 64,
  parameter int SRAM_W = 128,
  localparam int IDX_W = $clog2(SETS),
  localparam int BYTES = SRAM_W / 8
) (
  input  logic              clk,
  input  logic              en_i,
  input  logic              wrEn_i,
  input  logic [BYTES-1:0]  byteEn_i,
  input  logic [IDX_W-1:0]  addr_i,
  input  logic [SRAM_W-1:0] wrData_i,
  output logic [SRAM_W-1:0] rdData_o
);

  // behavioural model of a single-port macro with byte write enables
  logic [BYTES-1:0][7:0] mem [SETS];
  logic [BYTES-1:0][7:0] wrBytes;

  assign wrBytes = wrData_i;

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (wrEn_i) begin
        for (int b = 0; b < BYTES; b++) begin
          if (byteEn_i[b]) begin
            mem[addr_i][b] <= wrBytes[b];
          end
        end
      end else begin
        // read data appears the cycle after the enable
        rdData_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== hdl/memBusPkg.sv ====
package memBusPkg;

  // one refill beat carries one data word
  localparam int BEAT_W = 64;
  localparam int BEATS = 4;
  localparam int LINE_W = BEAT_W * BEATS;

  // refill bus sequencer
  typedef enum logic {
    R_IDLE,
    R_WAIT
  } refillState_e;

endpackage

// ==== hdl/refillIf.sv ====
interface refillIf;

  // one-cycle start pulse with the line-aligned address
  logic                         start;
  logic [cachePkg::ADDR_W-1:0]  lineAddr;

  // one-cycle done pulse, lineData stays valid until the next start
  logic                         done;
  logic [memBusPkg::LINE_W-1:0] lineData;

  modport ctrl (
    output start, lineAddr,
    input  done, lineData
  );

  modport refill (
    input  start, lineAddr,
    output done, lineData
  );

endinterface

// ==== hdl/refillUnit.sv ====
module refillUnit (
  input  logic                         clk,
  input  logic                         rst_n,
  refillIf.refill                      refillPort,
  output logic                         cacheRdValid_o,
  output logic [cachePkg::ADDR_W-1:0]  cacheAddr_o,
  input  logic                         rdDataValid_i,
  input  logic                         rdLast_i,
  input  logic [memBusPkg::BEAT_W-1:0] rdData_i
);

  localparam int CNT_W = $clog2(memBusPkg::BEATS);

  memBusPkg::refillState_e stateQ;
  logic [CNT_W-1:0] beatQ;
  logic doneQ;
  logic [cachePkg::ADDR_W-1:0] addrQ;
  logic [memBusPkg::BEATS-1:0][memBusPkg::BEAT_W-1:0] lineQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= memBusPkg::R_IDLE;
      beatQ <= '0;
      doneQ <= 1'b0;
    end else begin
      doneQ <= 1'b0;
      case (stateQ)
        memBusPkg::R_IDLE: begin
          if (refillPort.start) begin
            stateQ <= memBusPkg::R_WAIT;
            beatQ <= '0;
          end
        end
        memBusPkg::R_WAIT: begin
          if (rdDataValid_i) begin
            beatQ <= beatQ + 1'b1;
            if (rdLast_i) begin
              stateQ <= memBusPkg::R_IDLE;
              doneQ <= 1'b1;
            end
          end
        end
        default: stateQ <= memBusPkg::R_IDLE;
      endcase
    end
  end

  // address held for the whole burst
  always_ff @(posedge clk) begin
    if (stateQ == memBusPkg::R_IDLE && refillPort.start) begin
      addrQ <= refillPort.lineAddr;
    end
  end

  // beats arrive in address order, word 0 first
  always_ff @(posedge clk) begin
    if (stateQ == memBusPkg::R_WAIT && rdDataValid_i) begin
      lineQ[beatQ] <= rdData_i;
    end
  end

  assign cacheRdValid_o = (stateQ == memBusPkg::R_WAIT);
  assign cacheAddr_o = addrQ;
  assign refillPort.done = doneQ;
  assign refillPort.lineData = lineQ;

endmodule

// ==== hdl/tagIf.sv ====
interface tagIf #(
  parameter int SETS = 64
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = cachePkg::ADDR_W - IDX_W - cachePkg::OFFSET_W;

  // lookup and update requests from the controller
  logic             lookupEn;
  logic [IDX_W-1:0] lookupIndex;
  logic [TAG_W-1:0] cmpTag;
  logic             updateEn;
  logic             updateWay;
  logic             touchEn;

  // compare results, valid one cycle after lookupEn
  logic             hit;
  logic             hitWay;
  logic             victimWay;

  modport ctrl (
    output lookupEn, lookupIndex, cmpTag, updateEn, updateWay, touchEn,
    input  hit, hitWay, victimWay
  );

  modport array (
    input  lookupEn, lookupIndex, cmpTag, updateEn, updateWay, touchEn,
    output hit, hitWay, victimWay
  );

endinterface

// ==== hdl/tagValidArray.sv ====
module tagValidArray #(
  parameter int SETS = 64,
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cachePkg::ADDR_W - IDX_W - cachePkg::OFFSET_W
) (
  input  logic clk,
  input  logic rst_n,
  tagIf.array  tagPort
);

  logic [TAG_W-1:0] tagMem [2][SETS];
  logic [1:0][SETS-1:0] validQ;
  // per set, the way that was used least recently
  logic [SETS-1:0] lruQ;
  logic [IDX_W-1:0] idxQ;
  logic [1:0] wayValid;
  logic [1:0] wayHit;

  // compare against the set latched on the last lookup
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayValid[w] = validQ[w][idxQ];
      wayHit[w] = wayValid[w] && (tagMem[w][idxQ] == tagPort.cmpTag);
    end
  end

  assign tagPort.hit = |wayHit;
  assign tagPort.hitWay = wayHit[1];

  // fill an empty way first, otherwise evict the lru way
  always_comb begin
    if (!wayValid[0]) begin
      tagPort.victimWay = 1'b0;
    end else if (!wayValid[1]) begin
      tagPort.victimWay = 1'b1;
    end else begin
      tagPort.victimWay = lruQ[idxQ];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idxQ <= '0;
      validQ <= '0;
      lruQ <= '0;
    end else begin
      if (tagPort.lookupEn) begin
        idxQ <= tagPort.lookupIndex;
      end
      if (tagPort.updateEn) begin
        validQ[tagPort.updateWay][idxQ] <= 1'b1;
        lruQ[idxQ] <= ~tagPort.updateWay;
      end else if (tagPort.touchEn) begin
        lruQ[idxQ] <= ~tagPort.hitWay;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tagPort.updateEn) begin
      tagMem[tagPort.updateWay][idxQ] <= tagPort.cmpTag;
    end
  end

endmodule

// ==== verif/cacheTb.sv ====
module cacheTb;

  localparam int SETS = 64;
  localparam int SRAM_W = 128;
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = cachePkg::ADDR_W - IDX_W - cachePkg::OFFSET_W;
  localparam int DRIVE_DLY = 2;
  localparam int TIMEOUT_CYCLES = 100;
  localparam logic [31:0] SEED = 32'hae92_454b;

  typedef struct {
    cachePkg::memOp_e op;
    logic [31:0]      addr;
    logic [63:0]      data;
    logic [7:0]       mask;
    logic [63:0]      expData;
    bit               expHit;
  } stimEntry_t;

  logic clk;
  logic rst_n;
  logic valid_i;
  cachePkg::memOp_e op_i;
  logic [31:0] addr_i;
  logic [63:0] wr_data_i;
  logic [7:0] wr_mask_i;
  logic addr_ok_o;
  logic data_ok_o;
  logic [63:0] rd_data_o;
  logic cacheRdValid_o;
  logic [31:0] cacheAddr_o;
  logic rdDataValid_i;
  logic rdLast_i;
  logic [63:0] rdData_i;

  stimEntry_t stimTable[$];
  int pendIdx[$];
  int pendCycle[$];
  int pendRefills[$];
  int refillCount;
  int missCount;
  int cycleCount;
  logic [31:0] lastRefillAddr;

  // shadow cache state
  bit shValid[SETS][2];
  logic [TAG_W-1:0] shTag[SETS][2];
  logic [63:0] shData[SETS][2][4];
  bit shLru[SETS];

  cacheTop #(.SETS(SETS), .SRAM_W(SRAM_W)) dut_i (
    .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .op_i(op_i), .addr_i(addr_i),
    .wr_data_i(wr_data_i), .wr_mask_i(wr_mask_i), .addr_ok_o(addr_ok_o),
    .data_ok_o(data_ok_o), .rd_data_o(rd_data_o), .cacheRdValid_o(cacheRdValid_o),
    .cacheAddr_o(cacheAddr_o), .rdDataValid_i(rdDataValid_i), .rdLast_i(rdLast_i),
    .rdData_i(rdData_i)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // word at address a in backing memory
  function automatic logic [63:0] pattern(input logic [31:0] a);
    return {~a, a};
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
    if (got !== expected) begin
      abortRun($sformatf("[FAIL] time %0t: %s got %h, expected %h",
                         $time, name, got, expected));
    end
  endtask

  // stop at the first failed checker assertion
  always @(negedge clk) begin
    if (dut_i.checkerInst.errCount != 0) begin
      abortRun("an assertion in the bound checker failed");
    end
  end

  task automatic addReq(input cachePkg::memOp_e op, input logic [31:0] addr,
                        input logic [63:0] data, input logic [7:0] mask);
    stimEntry_t e;
    e.op = op;
    e.addr = addr;
    e.data = data;
    e.mask = mask;
    e.expData = '0;
    e.expHit = 1'b0;
    stimTable.push_back(e);
  endtask

  // fill on miss, lru victim, masked store merge, stores lost on eviction
  task automatic computeExpected();
    stimEntry_t e;
    logic [IDX_W-1:0] setIdx;
    logic [TAG_W-1:0] tag;
    logic [63:0] cur;
    int wordSel;
    int way;
    bit hit;
    missCount = 0;
    for (int k = 0; k < stimTable.size(); k++) begin
      e = stimTable[k];
      setIdx = e.addr[cachePkg::OFFSET_W +: IDX_W];
      tag = e.addr[cachePkg::ADDR_W-1 -: TAG_W];
      wordSel = e.addr[4:3];
      hit = 1'b0;
      way = 0;
      for (int w = 0; w < 2; w++) begin
        if (shValid[setIdx][w] && shTag[setIdx][w] == tag) begin
          hit = 1'b1;
          way = w;
        end
      end
      if (!hit) begin
        if (!shValid[setIdx][0]) begin
          way = 0;
        end else if (!shValid[setIdx][1]) begin
          way = 1;
        end else begin
          way = shLru[setIdx];
        end
        shValid[setIdx][way] = 1'b1;
        shTag[setIdx][way] = tag;
        for (int i = 0; i < 4; i++) begin
          shData[setIdx][way][i] = pattern({e.addr[31:5], 5'b0} + 32'(i * 8));
        end
        missCount++;
      end
      // other way becomes least recently used
      shLru[setIdx] = (way == 0);
      cur = shData[setIdx][way][wordSel];
      if (e.op == cachePkg::OP_WRITE) begin
        for (int b = 0; b < 8; b++) begin
          if (e.mask[b]) begin
            cur[b*8 +: 8] = e.data[b*8 +: 8];
          end
        end
        shData[setIdx][way][wordSel] = cur;
      end
      e.expData = cur;
      e.expHit = hit;
      stimTable[k] = e;
    end
  endtask

  task automatic driveEntry(input int k);
    valid_i = 1'b1;
    op_i = stimTable[k].op;
    addr_i = stimTable[k].addr;
    wr_data_i = stimTable[k].data;
    wr_mask_i = stimTable[k].mask;
  endtask

  task automatic checkResult(input int k, input int acceptCycle, input int refillsAtAccept);
    if (stimTable[k].op == cachePkg::OP_READ) begin
      checkValue("rd_data_o", rd_data_o, stimTable[k].expData);
    end
    checkValue("refills for request", refillCount - refillsAtAccept,
               stimTable[k].expHit ? 0 : 1);
    if (stimTable[k].expHit) begin
      checkValue("hit latency", cycleCount - acceptCycle, 1);
    end else begin
      checkValue("cacheAddr_o", lastRefillAddr, {stimTable[k].addr[31:5], 5'b0});
    end
  endtask

  // refill memory, random start delay and gaps between beats
  initial begin
    int seedDummy;
    int gapLeft;
    int beatIdx;
    bit inBurst;
    rdDataValid_i = 1'b0;
    rdLast_i = 1'b0;
    rdData_i = '0;
    refillCount = 0;
    lastRefillAddr = '0;
    inBurst = 1'b0;
    beatIdx = 0;
    gapLeft = 0;
    seedDummy = $urandom(SEED);
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      rdDataValid_i = 1'b0;
      rdLast_i = 1'b0;
      if (!cacheRdValid_o) begin
        inBurst = 1'b0;
      end else begin
        if (!inBurst) begin
          inBurst = 1'b1;
          beatIdx = 0;
          gapLeft = $urandom_range(2, 0);
          refillCount++;
          lastRefillAddr = cacheAddr_o;
        end
        if (gapLeft > 0) begin
          gapLeft--;
        end else if (beatIdx < memBusPkg::BEATS) begin
          rdDataValid_i = 1'b1;
          rdLast_i = (beatIdx == memBusPkg::BEATS - 1);
          rdData_i = pattern(cacheAddr_o + 32'(beatIdx * 8));
          beatIdx++;
          gapLeft = $urandom_range(2, 0);
        end
      end
    end
  end

  initial begin
    int nextIdx;
    int doneCount;
    int idleCycles;
    rst_n = 1'b0;
    valid_i = 1'b0;
    op_i = cachePkg::OP_READ;
    addr_i = '0;
    wr_data_i = '0;
    wr_mask_i = '0;

    // first fill, then hits in the same line
    addReq(cachePkg::OP_READ, 32'h0000_1048, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1058, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1040, '0, '0);
    // partial store then read back
    addReq(cachePkg::OP_WRITE, 32'h0000_1050, 64'h1122_3344_5566_7788, 8'ha5);
    addReq(cachePkg::OP_READ, 32'h0000_1050, '0, '0);
    // lines 0x1040, 0x1840 and 0x2040 all map to set 2
    addReq(cachePkg::OP_WRITE, 32'h0000_1848, 64'hdead_beef_cafe_f00d, 8'h0f);
    addReq(cachePkg::OP_READ, 32'h0000_1848, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_2040, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1848, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1050, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_2048, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1848, '0, '0);
    // back to back hits, a miss in set 5, a pipelined store
    addReq(cachePkg::OP_READ, 32'h0000_1840, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1850, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1858, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_30a0, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_30a8, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_30b8, '0, '0);
    addReq(cachePkg::OP_WRITE, 32'h0000_30b0, 64'h0123_4567_89ab_cdef, 8'hff);
    addReq(cachePkg::OP_READ, 32'h0000_30b0, '0, '0);
    addReq(cachePkg::OP_READ, 32'h0000_1840, '0, '0);
    computeExpected();

    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    checkValue("addr_ok_o", addr_ok_o, 0);
    checkValue("data_ok_o", data_ok_o, 0);
    checkValue("cacheRdValid_o", cacheRdValid_o, 0);

    nextIdx = 0;
    doneCount = 0;
    idleCycles = 0;
    cycleCount = 0;
    @(posedge clk);
    #DRIVE_DLY;
    driveEntry(nextIdx);
    while (doneCount < stimTable.size()) begin
      @(negedge clk);
      if (data_ok_o) begin
        if (pendIdx.size() == 0) begin
          abortRun("data_ok_o pulsed with no request outstanding");
        end
        checkResult(pendIdx.pop_front(), pendCycle.pop_front(), pendRefills.pop_front());
        doneCount++;
        idleCycles = 0;
      end
      if (addr_ok_o) begin
        if (nextIdx >= stimTable.size()) begin
          abortRun("addr_ok_o pulsed with no request presented");
        end
        pendIdx.push_back(nextIdx);
        pendCycle.push_back(cycleCount);
        pendRefills.push_back(refillCount);
        nextIdx++;
        idleCycles = 0;
      end
      idleCycles++;
      if (idleCycles > TIMEOUT_CYCLES) begin
        abortRun("timeout: the cache neither accepted a request nor returned a result");
      end
      @(posedge clk);
      #DRIVE_DLY;
      cycleCount++;
      if (nextIdx < stimTable.size()) begin
        driveEntry(nextIdx);
      end else begin
        valid_i = 1'b0;
      end
    end

    // no stray results once the table is drained
    repeat (4) begin
      @(negedge clk);
      checkValue("data_ok_o", data_ok_o, 0);
    end
    checkValue("total refills", refillCount, missCount);
    if (dut_i.checkerInst.errCount != 0) begin
      abortRun("an assertion in the bound checker failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== verif/cacheTop_checker.sv ====
module cacheTopChecker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  valid_i,
  input logic                  addrOk_i,
  input logic                  dataOk_i,
  input logic                  rdValid_i,
  input logic [31:0]           rdAddr_i,
  input logic                  beatValid_i,
  input logic                  beatLast_i,
  input cachePkg::cacheState_e ctrlState_i
);

  // failed assertion count
  int errCount = 0;

  // acceptance only for a presented request
  assert property (@(posedge clk) disable iff (!rst_n) addrOk_i |-> valid_i)
    else begin
      errCount++;
      $error("addr_ok_o raised while valid_i was low");
    end

  assert property (@(posedge clk) disable iff (!rst_n) !(dataOk_i && rdValid_i))
    else begin
      errCount++;
      $error("data_ok_o raised during a refill burst");
    end

  // refill address held for the whole burst
  assert property (@(posedge clk) disable iff (!rst_n)
    (rdValid_i && $past(rdValid_i)) |-> $stable(rdAddr_i))
    else begin
      errCount++;
      $error("cacheAddr_o changed while cacheRdValid_o was high");
    end

  assert property (@(posedge clk) disable iff (!rst_n) beatLast_i |-> beatValid_i)
    else begin
      errCount++;
      $error("rdLast_i arrived without rdDataValid_i");
    end

  // a replayed request always hits
  assert property (@(posedge clk) disable iff (!rst_n)
    ctrlState_i == cachePkg::REPLAY |=> dataOk_i)
    else begin
      errCount++;
      $error("the lookup after a refill did not hit");
    end

endmodule

bind cacheTop cacheTopChecker checkerInst (
  .clk        (clk),
  .rst_n      (rst_n),
  .valid_i    (valid_i),
  .addrOk_i   (addr_ok_o),
  .dataOk_i   (data_ok_o),
  .rdValid_i  (cacheRdValid_o),
  .rdAddr_i   (cacheAddr_o),
  .beatValid_i(rdDataValid_i),
  .beatLast_i (rdLast_i),
  .ctrlState_i(ctrlInst.stateQ)
);
